// ==== hdl/sensor_dma_pkg.sv ====
// ----------------------------------------------------------
// Shared widths, register maps and bus structs for the sensor DMA block
// FIFO depth must stay a power of two so the pointers wrap on their own
// ----------------------------------------------------------
package sensor_dma_pkg;

    // Bus widths
    localparam int ADR_W = 10;
    localparam int DAT_W = 32;

    // FIFO sizing
    localparam int CNT_W = 5;
    localparam int PTR_W = 4;
    localparam int OVR_W = 16;
    localparam logic [CNT_W-1:0] FIFO_DEPTH       = 5'd16;
    // DMA request once the count goes above this
    localparam logic [CNT_W-1:0] DMA_START_THRESH = 5'd8;

    // Fixed read values
    localparam logic [DAT_W-1:0] DEVICE_ID     = 32'h0005_5ADC;
    localparam logic [DAT_W-1:0] REV_NUM       = 32'h0000_0211;
    localparam logic [DAT_W-1:0] DEF_REG_VALUE = 32'hFABD_EFAC;

    // ------------------------------------------------------------
    // Register maps
    // ------------------------------------------------------------
    typedef enum logic [ADR_W-1:0] {
        REG_ID          = 10'h000,
        REG_REV         = 10'h001,
        REG_FIFO_RST    = 10'h002,
        REG_SENSOR_EN   = 10'h003,
        REG_OVRRUN      = 10'h004,  // {counter, 15'b0, flag}
        REG_SENSOR_DATA = 10'h040
    } fabric_reg_e;

    typedef enum logic [ADR_W-1:0] {
        REG_DMA_EN      = 10'h000,
        REG_DMA_STS     = 10'h001,
        REG_DMA_INTR_EN = 10'h002
    } dma_reg_e;

    // ------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------
    // Host request, held stable by the host until the acknowledge
    typedef struct packed {
        logic [ADR_W-1:0] adr;
        logic [3:0]       byte_stb;
        logic             we;
        logic [DAT_W-1:0] dat;
    } wb_req_t;

    // One-cycle write strobes, valid in the acknowledge cycle
    typedef struct packed {
        logic fifo_rst_wr;
        logic sensor_en_wr;
        logic dat0;
    } fabric_wr_t;

    typedef struct packed {
        logic en_wr;
        logic sts_wr;
        logic intr_en_wr;
        logic dat0;
    } dma_wr_t;

    typedef struct packed {
        logic [CNT_W-1:0] cnt;
        logic             full;
        logic             empty;
        logic             ovr_flag;
        logic [OVR_W-1:0] ovr_cnt;
    } fifo_status_t;

endpackage

// ==== hdl/wb_cycle_decode.sv ====
// ----------------------------------------------------------
// One acknowledge per access; a held strobe gets no second one
// Host must hold address, data and select through the acknowledge
// ----------------------------------------------------------
module wb_cycle_decode (
    input  logic                      WBs_CLK_i,
    input  logic                      WBs_RST_i,
    input  logic                      cyc_fabric_i,
    input  logic                      cyc_dma_reg_i,
    input  logic                      cyc_dma_dat_i,
    input  logic                      stb_i,
    input  sensor_dma_pkg::wb_req_t   req_i,
    output logic                      ack_o,
    output sensor_dma_pkg::fabric_wr_t fabric_wr_o,
    output sensor_dma_pkg::dma_wr_t   dma_wr_o,
    output logic                      fifo_pop_o
);

    logic acc;
    logic acc_q;
    logic wr_ok;

    // Any of the three selects with the strobe
    assign acc = (cyc_fabric_i | cyc_dma_reg_i | cyc_dma_dat_i) & stb_i;

    // Rising edge of the access gives the acknowledge
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            acc_q      <= 1'b0;
            ack_o      <= 1'b0;
            fifo_pop_o <= 1'b0;
        end
        else
        begin
            acc_q      <= acc;
            ack_o      <= acc & ~acc_q;
            // Pop lines up with the acknowledge of a data access
            fifo_pop_o <= cyc_dma_dat_i & stb_i & ~acc_q;
        end
    end

    // Write qualifier, only byte lane 0 matters
    assign wr_ok = ack_o & stb_i & req_i.we & req_i.byte_stb[0];

    // Per-register strobes, committed on the edge ending the acknowledge
    always_comb
    begin
        fabric_wr_o.fifo_rst_wr  = wr_ok & cyc_fabric_i & (req_i.adr == sensor_dma_pkg::REG_FIFO_RST);
        fabric_wr_o.sensor_en_wr = wr_ok & cyc_fabric_i & (req_i.adr == sensor_dma_pkg::REG_SENSOR_EN);
        fabric_wr_o.dat0         = req_i.dat[0];
        dma_wr_o.en_wr           = wr_ok & cyc_dma_reg_i & (req_i.adr == sensor_dma_pkg::REG_DMA_EN);
        dma_wr_o.sts_wr          = wr_ok & cyc_dma_reg_i & (req_i.adr == sensor_dma_pkg::REG_DMA_STS);
        dma_wr_o.intr_en_wr      = wr_ok & cyc_dma_reg_i & (req_i.adr == sensor_dma_pkg::REG_DMA_INTR_EN);
        dma_wr_o.dat0            = req_i.dat[0];
    end

    // Acknowledge only while the host still holds the access, and single-cycle
    ack_single: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        ack_o |-> acc ##1 !ack_o);

endmodule

// ==== hdl/fabric_reg_bank.sv ====
// ----------------------------------------------------------
// Fabric registers; spi_tfer_done_i wins over a sensor enable write
// Last sensor word holds X until the first push
// ----------------------------------------------------------
module fabric_reg_bank (
    input  logic                                WBs_CLK_i,
    input  logic                                WBs_RST_i,
    input  sensor_dma_pkg::fabric_wr_t          wr_i,
    input  logic [sensor_dma_pkg::ADR_W-1:0]    adr_i,
    input  logic                                spi_tfer_done_i,
    input  logic                                sensor_push_i,
    input  logic [sensor_dma_pkg::DAT_W-1:0]    sensor_data_i,
    input  sensor_dma_pkg::fifo_status_t        fifo_stat_i,
    output logic                                sensor_enable_o,
    output logic                                fifo_flush_o,
    output logic [sensor_dma_pkg::DAT_W-1:0]    rd_data_o
);

    logic [sensor_dma_pkg::DAT_W-1:0] sensor_word;

    // ------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            sensor_enable_o <= 1'b0;
            fifo_flush_o    <= 1'b0;
        end
        else
        begin
            // Transfer done ends the sensor session
            if (spi_tfer_done_i)
                sensor_enable_o <= 1'b0;
            else if (wr_i.sensor_en_wr)
                sensor_enable_o <= wr_i.dat0;

            // Flush request self-clears after one cycle
            fifo_flush_o <= wr_i.fifo_rst_wr & wr_i.dat0;
        end
    end

    // Last word seen, taken even when the FIFO drops it
    always_ff @(posedge WBs_CLK_i)
    begin
        if (sensor_push_i)
            sensor_word <= sensor_data_i;
    end

    // ------------------------------------------------------------
    // Read multiplexer
    // ------------------------------------------------------------
    always_comb
    begin
        case (sensor_dma_pkg::fabric_reg_e'(adr_i))
            sensor_dma_pkg::REG_ID:
                rd_data_o = sensor_dma_pkg::DEVICE_ID;
            sensor_dma_pkg::REG_REV:
                rd_data_o = sensor_dma_pkg::REV_NUM;
            sensor_dma_pkg::REG_FIFO_RST:
                rd_data_o = {31'b0, fifo_flush_o};
            sensor_dma_pkg::REG_SENSOR_EN:
                rd_data_o = {31'b0, sensor_enable_o};
            sensor_dma_pkg::REG_OVRRUN:
                rd_data_o = {fifo_stat_i.ovr_cnt, 15'b0, fifo_stat_i.ovr_flag};
            sensor_dma_pkg::REG_SENSOR_DATA:
                rd_data_o = sensor_word;
            default:
                rd_data_o = sensor_dma_pkg::DEF_REG_VALUE;
        endcase
    end

    // Flush is a pulse, never a level
    flush_pulse: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        fifo_flush_o |=> !fifo_flush_o);

endmodule

// ==== hdl/dma_ctrl_regs.sv ====
// ----------------------------------------------------------
// DMA bank; done pulse beats a status write, enable write beats clear
// ----------------------------------------------------------
module dma_ctrl_regs (
    input  logic                                WBs_CLK_i,
    input  logic                                WBs_RST_i,
    input  sensor_dma_pkg::dma_wr_t             wr_i,
    input  logic [sensor_dma_pkg::ADR_W-1:0]    adr_i,
    input  logic                                dma_clr_i,
    input  logic                                dma_done_i,
    input  sensor_dma_pkg::fifo_status_t        fifo_stat_i,
    output logic                                dma_enable_o,
    output logic                                dma_start_o,
    output logic                                done_irq_o,
    output logic [sensor_dma_pkg::DAT_W-1:0]    rd_data_o
);

    logic intr_en;
    logic done_sts;

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            dma_enable_o <= 1'b0;
            intr_en      <= 1'b0;
            done_sts     <= 1'b0;
        end
        else
        begin
            // Engine clear drops the enable unless software writes it
            if (wr_i.en_wr)
                dma_enable_o <= wr_i.dat0;
            else if (dma_clr_i)
                dma_enable_o <= 1'b0;

            if (wr_i.intr_en_wr)
                intr_en <= wr_i.dat0;

            // Sticky done, software writes 0 to clear
            if (dma_done_i)
                done_sts <= 1'b1;
            else if (wr_i.sts_wr)
                done_sts <= wr_i.dat0;
        end
    end

    // Request a burst once enough words are waiting
    assign dma_start_o = (fifo_stat_i.cnt > sensor_dma_pkg::DMA_START_THRESH) & dma_enable_o;

    // Interrupt is masked status
    assign done_irq_o  = done_sts & intr_en;

    always_comb
    begin
        case (sensor_dma_pkg::dma_reg_e'(adr_i))
            sensor_dma_pkg::REG_DMA_EN:      rd_data_o = {31'b0, dma_enable_o};
            sensor_dma_pkg::REG_DMA_STS:     rd_data_o = {31'b0, done_sts};
            sensor_dma_pkg::REG_DMA_INTR_EN: rd_data_o = {31'b0, intr_en};
            default:                         rd_data_o = sensor_dma_pkg::DEF_REG_VALUE;
        endcase
    end

endmodule

// ==== hdl/sensor_rx_fifo.sv ====
// ----------------------------------------------------------
// First-word-fall-through FIFO; head_o is valid only while not empty
// Pushes into a full FIFO are lost and counted as overruns
// ----------------------------------------------------------
module sensor_rx_fifo (
    input  logic                                WBs_CLK_i,
    input  logic                                WBs_RST_i,
    input  logic                                flush_i,
    input  logic                                push_i,
    input  logic [sensor_dma_pkg::DAT_W-1:0]    push_data_i,
    input  logic                                pop_i,
    output logic [sensor_dma_pkg::DAT_W-1:0]    head_o,
    output sensor_dma_pkg::fifo_status_t        stat_o
);

    logic [sensor_dma_pkg::DAT_W-1:0] mem [sensor_dma_pkg::FIFO_DEPTH];
    logic [sensor_dma_pkg::PTR_W-1:0] wr_ptr;
    logic [sensor_dma_pkg::PTR_W-1:0] rd_ptr;
    logic [sensor_dma_pkg::CNT_W-1:0] cnt;
    logic                             ovr_flag;
    logic [sensor_dma_pkg::OVR_W-1:0] ovr_cnt;
    logic                             full;
    logic                             empty;
    logic                             push_ok;
    logic                             pop_ok;

    assign full    = (cnt == sensor_dma_pkg::FIFO_DEPTH);
    assign empty   = (cnt == '0);
    assign push_ok = push_i & ~full & ~flush_i;
    assign pop_ok  = pop_i & ~empty & ~flush_i;

    // ------------------------------------------------------------
    // Pointers, count and overrun tracking
    // ------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            cnt      <= '0;
            ovr_flag <= 1'b0;
            ovr_cnt  <= '0;
        end
        else if (flush_i)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            cnt      <= '0;
            ovr_flag <= 1'b0;
            ovr_cnt  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous push and pop leave the count alone
            if (push_ok & ~pop_ok)
                cnt <= cnt + 1'b1;
            else if (pop_ok & ~push_ok)
                cnt <= cnt - 1'b1;
            // Dropped word
            if (push_i & full)
            begin
                ovr_flag <= 1'b1;
                ovr_cnt  <= ovr_cnt + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge WBs_CLK_i)
    begin
        if (push_ok)
            mem[wr_ptr] <= push_data_i;
    end

    assign head_o = mem[rd_ptr];

    always_comb
    begin
        stat_o.cnt      = cnt;
        stat_o.full     = full;
        stat_o.empty    = empty;
        stat_o.ovr_flag = ovr_flag;
        stat_o.ovr_cnt  = ovr_cnt;
    end

    cnt_bound: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        cnt <= sensor_dma_pkg::FIFO_DEPTH);

    // When full the write slot is the oldest word, a dropped push must not touch it
    no_wr_full: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        (full && push_i && !pop_i && !flush_i) |=> $stable(head_o));

endmodule

// ==== hdl/sensor_dma_top.sv ====
// ----------------------------------------------------------
// Sensor capture top; one shared acknowledge for all three selects
// ----------------------------------------------------------
module sensor_dma_top (
    input  logic                                WBs_CLK_i,
    input  logic                                WBs_RST_i,
    input  logic [sensor_dma_pkg::ADR_W-1:0]    WBs_ADR_i,
    input  logic                                WBs_CYC_i,
    input  logic                                WBs_CYC_DMA_REG_i,
    input  logic                                WBs_CYC_DMA_DAT_i,
    input  logic [3:0]                          WBs_BYTE_STB_i,
    input  logic                                WBs_WE_i,
    input  logic                                WBs_STB_i,
    input  logic [sensor_dma_pkg::DAT_W-1:0]    WBs_DAT_i,
    output logic                                WBs_ACK_o,
    output logic [sensor_dma_pkg::DAT_W-1:0]    WBs_DAT_o,
    output logic [sensor_dma_pkg::DAT_W-1:0]    WBs_DMA_REG_o,
    output logic [sensor_dma_pkg::DAT_W-1:0]    WBs_DMA_DAT_o,
    input  logic [sensor_dma_pkg::DAT_W-1:0]    Sensor_RD_Data_i,
    input  logic                                Sensor_RD_Push_i,
    input  logic                                spi_tfer_done_i,
    input  logic                                DMA0_Clr_i,
    input  logic                                DMA0_Done_i,
    output logic                                Sensor_Enable_o,
    output logic                                rx_fifo_full_o,
    output logic                                DMA0_Start_o,
    output logic                                DMA_Enable_o,
    output logic                                DMA0_Done_IRQ_o
);

    sensor_dma_pkg::wb_req_t      req;
    sensor_dma_pkg::fabric_wr_t   fab_wr;
    sensor_dma_pkg::dma_wr_t      dma_wr;
    sensor_dma_pkg::fifo_status_t fifo_stat;
    logic                         fifo_pop;
    logic                         fifo_flush;

    // Bundle the host request
    assign req = '{adr: WBs_ADR_i, byte_stb: WBs_BYTE_STB_i, we: WBs_WE_i, dat: WBs_DAT_i};

    wb_cycle_decode u_wb_cycle_decode (
        .WBs_CLK_i, .WBs_RST_i,
        .cyc_fabric_i (WBs_CYC_i),         .cyc_dma_reg_i (WBs_CYC_DMA_REG_i),
        .cyc_dma_dat_i(WBs_CYC_DMA_DAT_i), .stb_i         (WBs_STB_i),
        .req_i        (req),               .ack_o         (WBs_ACK_o),
        .fabric_wr_o  (fab_wr),            .dma_wr_o      (dma_wr),
        .fifo_pop_o   (fifo_pop)
    );

    fabric_reg_bank u_fabric_reg_bank (
        .WBs_CLK_i, .WBs_RST_i,
        .wr_i           (fab_wr),           .adr_i          (WBs_ADR_i),
        .spi_tfer_done_i(spi_tfer_done_i),  .sensor_push_i  (Sensor_RD_Push_i),
        .sensor_data_i  (Sensor_RD_Data_i), .fifo_stat_i    (fifo_stat),
        .sensor_enable_o(Sensor_Enable_o),  .fifo_flush_o   (fifo_flush),
        .rd_data_o      (WBs_DAT_o)
    );

    dma_ctrl_regs u_dma_ctrl_regs (
        .WBs_CLK_i, .WBs_RST_i,
        .wr_i        (dma_wr),       .adr_i      (WBs_ADR_i),
        .dma_clr_i   (DMA0_Clr_i),   .dma_done_i (DMA0_Done_i),
        .fifo_stat_i (fifo_stat),    .dma_enable_o(DMA_Enable_o),
        .dma_start_o (DMA0_Start_o), .done_irq_o (DMA0_Done_IRQ_o),
        .rd_data_o   (WBs_DMA_REG_o)
    );

    // Head word is the DMA read data
    sensor_rx_fifo u_sensor_rx_fifo (
        .WBs_CLK_i, .WBs_RST_i,
        .flush_i    (fifo_flush),       .push_i (Sensor_RD_Push_i),
        .push_data_i(Sensor_RD_Data_i), .pop_i  (fifo_pop),
        .head_o     (WBs_DMA_DAT_o),    .stat_o (fifo_stat)
    );

    assign rx_fifo_full_o = fifo_stat.full;

endmodule

// ==== bench/tb_sensor_dma_top.sv ====
// ----------------------------------------------------------
// Runs the command list in bench/sensor_dma_stimulus.txt from the project root
// Every access holds its strobe one extra cycle to catch a repeated acknowledge
// ----------------------------------------------------------
module tb_sensor_dma_top;

    localparam int ACK_TIMEOUT = 20;

    logic                             wb_clk;
    logic                             wb_rst;
    logic [sensor_dma_pkg::ADR_W-1:0] wb_adr;
    logic                             wb_cyc;
    logic                             wb_cyc_dma_reg;
    logic                             wb_cyc_dma_dat;
    logic [3:0]                       wb_byte_stb;
    logic                             wb_we;
    logic                             wb_stb;
    logic [31:0]                      wb_dat;
    logic                             wb_ack;
    logic [31:0]                      fab_rd;
    logic [31:0]                      dma_reg_rd;
    logic [31:0]                      dma_dat_rd;
    logic [31:0]                      sensor_data;
    logic                             sensor_push;
    logic                             spi_done;
    logic                             dma_clr;
    logic                             dma_done;
    logic                             sensor_en;
    logic                             fifo_full;
    logic                             dma_start;
    logic                             dma_en;
    logic                             done_irq;

    int mismatches;
    int timeouts;
    int faults;

    sensor_dma_top u_sensor_dma_top (
        .WBs_CLK_i        (wb_clk),         .WBs_RST_i        (wb_rst),
        .WBs_ADR_i        (wb_adr),         .WBs_CYC_i        (wb_cyc),
        .WBs_CYC_DMA_REG_i(wb_cyc_dma_reg), .WBs_CYC_DMA_DAT_i(wb_cyc_dma_dat),
        .WBs_BYTE_STB_i   (wb_byte_stb),    .WBs_WE_i         (wb_we),
        .WBs_STB_i        (wb_stb),         .WBs_DAT_i        (wb_dat),
        .WBs_ACK_o        (wb_ack),         .WBs_DAT_o        (fab_rd),
        .WBs_DMA_REG_o    (dma_reg_rd),     .WBs_DMA_DAT_o    (dma_dat_rd),
        .Sensor_RD_Data_i (sensor_data),    .Sensor_RD_Push_i (sensor_push),
        .spi_tfer_done_i  (spi_done),       .DMA0_Clr_i       (dma_clr),
        .DMA0_Done_i      (dma_done),       .Sensor_Enable_o  (sensor_en),
        .rx_fifo_full_o   (fifo_full),      .DMA0_Start_o     (dma_start),
        .DMA_Enable_o     (dma_en),         .DMA0_Done_IRQ_o  (done_irq)
    );

    // 40 unit clock
    initial wb_clk = 1'b0;
    always #20 wb_clk = ~wb_clk;

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        if (got !== exp)
        begin
            mismatches++;
            $display("MISMATCH at %0t: %s expected 0x%08h got 0x%08h", $time, name, exp, got);
        end
    endtask

    // ------------------------------------------------------------
    // Bus access, sel 0 fabric, 1 DMA registers, 2 FIFO data
    // ------------------------------------------------------------
    task automatic bus_access(input int sel, input logic we,
                              input logic [sensor_dma_pkg::ADR_W-1:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int   waited;
        logic got_ack;
        waited  = 0;
        got_ack = 1'b0;
        rdat    = '0;
        @(posedge wb_clk);
        wb_cyc         <= (sel == 0);
        wb_cyc_dma_reg <= (sel == 1);
        wb_cyc_dma_dat <= (sel == 2);
        wb_stb         <= 1'b1;
        wb_we          <= we;
        wb_adr         <= adr;
        wb_dat         <= wdat;
        wb_byte_stb    <= 4'hF;
        // Sample at the falling edge, read data is valid with the acknowledge
        while (!got_ack && waited < ACK_TIMEOUT)
        begin
            @(negedge wb_clk);
            waited++;
            if (wb_ack)
            begin
                got_ack = 1'b1;
                case (sel)
                    0:       rdat = fab_rd;
                    1:       rdat = dma_reg_rd;
                    default: rdat = dma_dat_rd;
                endcase
            end
        end
        if (!got_ack)
        begin
            timeouts++;
            $display("ERROR at %0t: no acknowledge within %0d cycles at address 0x%03h",
                     $time, ACK_TIMEOUT, adr);
        end
        else
        begin
            // Strobe still high, acknowledge must not come back
            @(negedge wb_clk);
            if (wb_ack)
            begin
                faults++;
                $display("ERROR at %0t: second acknowledge for a single access", $time);
            end
        end
        @(posedge wb_clk);
        wb_cyc         <= 1'b0;
        wb_cyc_dma_reg <= 1'b0;
        wb_cyc_dma_dat <= 1'b0;
        wb_stb         <= 1'b0;
        wb_we          <= 1'b0;
        wb_byte_stb    <= 4'h0;
    endtask

    // Back-to-back sensor pushes of base, base+1, ...
    task automatic push_words(input logic [31:0] base, input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge wb_clk);
            sensor_push <= 1'b1;
            sensor_data <= base + i;
        end
        @(posedge wb_clk);
        sensor_push <= 1'b0;
    endtask

    // FIFO data reads, words expected in push order
    task automatic pop_words(input logic [31:0] base, input int n);
        logic [31:0] rdat;
        for (int i = 0; i < n; i++)
        begin
            bus_access(2, 1'b0, '0, '0, rdat);
            compare_word("WBs_DMA_DAT_o", base + i, rdat);
        end
    endtask

    // Single-cycle pulse, 0 spi done, 1 DMA done, 2 DMA clear
    task automatic pulse_input(input int which);
        @(posedge wb_clk);
        case (which)
            0:       spi_done <= 1'b1;
            1:       dma_done <= 1'b1;
            default: dma_clr  <= 1'b1;
        endcase
        @(posedge wb_clk);
        spi_done <= 1'b0;
        dma_done <= 1'b0;
        dma_clr  <= 1'b0;
    endtask

    task automatic check_outputs(input logic full, input logic start, input logic irq,
                                 input logic sen, input logic den);
        @(negedge wb_clk);
        compare_word("rx_fifo_full_o", {31'b0, full}, {31'b0, fifo_full});
        compare_word("DMA0_Start_o", {31'b0, start}, {31'b0, dma_start});
        compare_word("DMA0_Done_IRQ_o", {31'b0, irq}, {31'b0, done_irq});
        compare_word("Sensor_Enable_o", {31'b0, sen}, {31'b0, sensor_en});
        compare_word("DMA_Enable_o", {31'b0, den}, {31'b0, dma_en});
    endtask

    // ------------------------------------------------------------
    // Command loop
    // ------------------------------------------------------------
    initial
    begin
        int          fd;
        int          nread;
        int          gap;
        int          sel;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] op_c;
        logic [31:0] op_d;
        logic [31:0] op_e;
        logic [31:0] rdat;
        mismatches = 0;
        timeouts   = 0;
        faults     = 0;
        void'($urandom(74));
        wb_rst         <= 1'b1;
        wb_adr         <= '0;
        wb_cyc         <= 1'b0;
        wb_cyc_dma_reg <= 1'b0;
        wb_cyc_dma_dat <= 1'b0;
        wb_byte_stb    <= 4'h0;
        wb_we          <= 1'b0;
        wb_stb         <= 1'b0;
        wb_dat         <= '0;
        sensor_data    <= '0;
        sensor_push    <= 1'b0;
        spi_done       <= 1'b0;
        dma_clr        <= 1'b0;
        dma_done       <= 1'b0;
        repeat (10) @(posedge wb_clk);
        wb_rst <= 1'b0;

        fd = $fopen("bench/sensor_dma_stimulus.txt", "r");
        if (fd == 0)
        begin
            faults++;
            $display("ERROR: stimulus file bench/sensor_dma_stimulus.txt could not be opened");
        end
        else
        begin
            while (!$feof(fd))
            begin
                nread = $fgets(line, fd);
                // Skip blank and comment lines
                if (nread == 0 || line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
                    continue;
                op_a = '0;
                op_b = '0;
                op_c = '0;
                op_d = '0;
                op_e = '0;
                void'($sscanf(line, "%c %h %h %h %h %h", cmd, op_a, op_b, op_c, op_d, op_e));
                gap = $urandom % 3;
                repeat (gap) @(posedge wb_clk);
                sel = (op_a == 32'd0) ? 0 : 1;
                case (cmd)
                    "W": bus_access(sel, 1'b1, op_b[sensor_dma_pkg::ADR_W-1:0], op_c, rdat);
                    "R":
                    begin
                        bus_access(sel, 1'b0, op_b[sensor_dma_pkg::ADR_W-1:0], '0, rdat);
                        compare_word((sel == 0) ? "WBs_DAT_o" : "WBs_DMA_REG_o", op_c, rdat);
                    end
                    "P": push_words(op_a, op_b);
                    "D": pop_words(op_a, op_b);
                    "E": check_outputs(op_a[0], op_b[0], op_c[0], op_d[0], op_e[0]);
                    "T": pulse_input(0);
                    "K": pulse_input(1);
                    "L": pulse_input(2);
                    default:
                    begin
                        faults++;
                        $display("ERROR: unknown command in stimulus line %s", line);
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts, faults);
        if (mismatches + timeouts + faults == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== bench/sensor_dma_stimulus.txt ====
# Hex operands. W/R: bank(0 fabric,1 dma) adr data|expect. P/D: first_word count
# E: full start irq sensor_en dma_en. T spi done, K DMA done, L DMA clear
R 0 000 00055ADC
R 0 001 00000211
R 0 123 FABDEFAC
R 1 007 FABDEFAC
E 0 0 0 0 0
W 0 003 00000001
R 0 003 00000001
E 0 0 0 1 0
T
E 0 0 0 0 0
P 12345678 1
R 0 040 12345678
D 12345678 1
W 1 000 00000001
P 00000A00 8
E 0 0 0 0 1
P 00000A08 1
E 0 1 0 0 1
P 00000A09 7
E 1 1 0 0 1
D 00000A00 7
E 0 1 0 0 1
D 00000A07 1
E 0 0 0 0 1
D 00000A08 8
E 0 0 0 0 1
P 00000B00 12
E 1 1 0 0 1
R 0 004 00020001
R 0 040 00000B11
W 0 002 00000001
E 0 0 0 0 1
R 0 004 00000000
K
R 1 001 00000001
E 0 0 0 0 1
W 1 002 00000001
E 0 0 1 0 1
W 1 001 00000000
R 1 001 00000000
E 0 0 0 0 1
L
E 0 0 0 0 0
R 1 000 00000000

// ==== sensor_dma_top.f ====
hdl/sensor_dma_pkg.sv
hdl/wb_cycle_decode.sv
hdl/fabric_reg_bank.sv
hdl/dma_ctrl_regs.sv
hdl/sensor_rx_fifo.sv
hdl/sensor_dma_top.sv
bench/tb_sensor_dma_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_sensor_dma_top \
    -f sensor_dma_top.f -o tb_sim

out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
